//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_ulx3s_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
design/board_pkg.sv
design/reset_stretch.sv
design/sd_spi_byte.sv
design/video_timing.sv
design/tmds_encoder.sv
design/main_core.sv
design/ulx3s_top.sv
sim/tb_video_check.sv
sim/tb_ulx3s_top.sv

//--- design/board_pkg.sv
`default_nettype none

package board_pkg;

  // 640x480 at 60 Hz with a 25 MHz pixel clock
  localparam logic [9:0] h_active = 10'd640;
  localparam logic [9:0] h_front  = 10'd16;
  localparam logic [9:0] h_sync   = 10'd96;
  localparam logic [9:0] h_back   = 10'd48;
  localparam logic [9:0] h_total  = h_active + h_front + h_sync + h_back;

  localparam logic [9:0] v_active = 10'd480;
  localparam logic [9:0] v_front  = 10'd10;
  localparam logic [9:0] v_sync   = 10'd2;
  localparam logic [9:0] v_back   = 10'd33;
  localparam logic [9:0] v_total  = v_active + v_front + v_sync + v_back;

  // Bits per pattern colour
  localparam int color_depth = 6;

  localparam logic [4:0] reset_stretch_len = 5'd16;

  // Clock cycles per half period of sd_clk
  localparam logic [3:0] spi_half_period = 4'd2;

  // Encoder depth, input to symbol
  localparam int tmds_latency = 2;

  // DVI control symbols, indexed by {c1, c0}
  localparam logic [9:0] tmds_ctrl_00 = 10'b1101010100;
  localparam logic [9:0] tmds_ctrl_01 = 10'b0010101011;
  localparam logic [9:0] tmds_ctrl_10 = 10'b0101010100;
  localparam logic [9:0] tmds_ctrl_11 = 10'b1010101011;

  // One 10-bit symbol, seen as a code word or as a data symbol
  typedef union packed {
    logic [9:0] raw;
    struct packed {
      logic       invert;
      logic       use_xor;
      logic [7:0] data;
    } fields;
  } tmds_symbol_t;

endpackage

`default_nettype wire

//--- design/main_core.sv
`timescale 1ns/100ps
`default_nettype none

module main_core
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  input  logic [6:1] btn,
  input  logic       sd_miso,
  output logic [7:0] led,
  output logic       sd_clk,
  output logic       sd_csn,
  output logic       sd_mosi,
  output logic [9:0] tmds_red,
  output logic [9:0] tmds_green,
  output logic [9:0] tmds_blue
);

  logic [9:0]             pix_x;
  logic [9:0]             pix_y;
  logic                   tim_de;
  logic                   tim_hsync;
  logic                   tim_vsync;
  logic [color_depth-1:0] red_c;
  logic [color_depth-1:0] green_c;
  logic [color_depth-1:0] blue_c;
  logic [7:0]             red_q;
  logic [7:0]             green_q;
  logic [7:0]             blue_q;
  logic                   de_q;
  logic                   hsync_q;
  logic                   vsync_q;
  logic [6:3]             nibble_q;
  logic                   btn1_q;
  logic                   btn1_prev;
  logic                   spi_start;
  logic                   spi_busy;
  logic                   spi_done;
  logic [7:0]             spi_rx;

  video_timing u_timing (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .x         (pix_x),
    .y         (pix_y),
    .de        (tim_de),
    .hsync     (tim_hsync),
    .vsync     (tim_vsync)
  );

  // Test pattern
  assign red_c   = pix_x[7:2];
  assign green_c = pix_y[7:2];
  assign blue_c  = pix_x[7:2] ^ pix_y[7:2];

  // Colour and sync registered together so all three lanes line up
  always_ff @(posedge clk_25mhz) begin
    red_q   <= {red_c, red_c[color_depth-1 -: 2]};
    green_q <= {green_c, green_c[color_depth-1 -: 2]};
    blue_q  <= {blue_c, blue_c[color_depth-1 -: 2]};
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      de_q    <= 1'b0;
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      de_q    <= tim_de;
      hsync_q <= tim_hsync;
      vsync_q <= tim_vsync;
    end
  end

  tmds_encoder u_enc_red (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .data      (red_q),
    .ctrl      (2'b00),
    .de        (de_q),
    .symbol    (tmds_red)
  );

  tmds_encoder u_enc_green (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .data      (green_q),
    .ctrl      (2'b00),
    .de        (de_q),
    .symbol    (tmds_green)
  );

  // Blue lane carries the syncs
  tmds_encoder u_enc_blue (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .data      (blue_q),
    .ctrl      ({vsync_q, hsync_q}),
    .de        (de_q),
    .symbol    (tmds_blue)
  );

  // Button sampling and rising edge of btn[1]
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      nibble_q  <= 4'h0;
      btn1_q    <= 1'b0;
      btn1_prev <= 1'b0;
    end else begin
      nibble_q  <= btn[6:3];
      btn1_q    <= btn[1];
      btn1_prev <= btn1_q;
    end
  end

  assign spi_start = btn1_q && !btn1_prev && !spi_busy;

  sd_spi_byte u_spi (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .start     (spi_start),
    .tx_byte   ({nibble_q, 4'h5}),
    .sd_miso   (sd_miso),
    .sd_clk    (sd_clk),
    .sd_csn    (sd_csn),
    .sd_mosi   (sd_mosi),
    .busy      (spi_busy),
    .done      (spi_done),
    .rx_byte   (spi_rx)
  );

  // Show the last byte read from the card
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      led <= 8'h00;
    end else if (spi_done) begin
      led <= spi_rx;
    end
  end

endmodule

`default_nettype wire

//--- design/reset_stretch.sv
`timescale 1ns/100ps
`default_nettype none

module reset_stretch
  import board_pkg::*;
(
  input  logic clk_25mhz,
  input  logic ready,
  output logic reset_out
);

  logic [4:0] count;

  // Reload while the button is held, then run down
  always_ff @(posedge clk_25mhz) begin
    if (!ready) begin
      count <= reset_stretch_len;
    end else if (count != 5'd0) begin
      count <= count - 5'd1;
    end
  end

  // Release once the count has drained
  assign reset_out = !ready || (count != 5'd0);

endmodule

`default_nettype wire

//--- design/sd_spi_byte.sv
`timescale 1ns/100ps
`default_nettype none

module sd_spi_byte
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] tx_byte,
  input  logic       sd_miso,
  output logic       sd_clk,
  output logic       sd_csn,
  output logic       sd_mosi,
  output logic       busy,
  output logic       done,
  output logic [7:0] rx_byte
);

  logic [3:0] div_count;
  logic [2:0] bit_count;
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;
  logic       half_end;
  logic       last_fall;

  assign half_end  = busy && (div_count == spi_half_period - 4'd1);
  assign last_fall = half_end && sd_clk && (bit_count == 3'd7);

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      sd_csn    <= 1'b1;
      sd_clk    <= 1'b0;
      sd_mosi   <= 1'b0;
      div_count <= 4'd0;
      bit_count <= 3'd0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy      <= 1'b1;
          sd_csn    <= 1'b0;
          sd_mosi   <= tx_byte[7];
          div_count <= 4'd0;
          bit_count <= 3'd0;
        end
      end else if (half_end) begin
        div_count <= 4'd0;
        sd_clk    <= !sd_clk;
        if (last_fall) begin
          busy    <= 1'b0;
          done    <= 1'b1;
          sd_csn  <= 1'b1;
          sd_mosi <= 1'b0;
        end else if (sd_clk) begin
          // Falling edge, present the next bit
          bit_count <= bit_count + 3'd1;
          sd_mosi   <= tx_shift[6];
        end
      end else begin
        div_count <= div_count + 4'd1;
      end
    end
  end

  // Data shifting, MSB first
  always_ff @(posedge clk_25mhz) begin
    if (!busy && start) begin
      tx_shift <= tx_byte;
    end else if (half_end && sd_clk) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    // Sample on the edge that raises sd_clk
    if (half_end && !sd_clk) begin
      rx_shift <= {rx_shift[6:0], sd_miso};
    end
    if (last_fall) begin
      rx_byte <= rx_shift;
    end
  end

endmodule

`default_nettype wire

//--- design/tmds_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module tmds_encoder
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  input  logic [7:0] data,
  input  logic [1:0] ctrl,
  input  logic       de,
  output logic [9:0] symbol
);

  logic [3:0]        ones_in;
  logic              use_xnor;
  logic [8:0]        q_m_next;
  logic [8:0]        q_m;
  logic              de_d;
  logic [1:0]        ctrl_d;
  logic [3:0]        ones_q;
  logic signed [5:0] q_diff;
  logic signed [5:0] disparity;
  logic signed [5:0] disparity_next;
  tmds_symbol_t      sym_next;

  // Stage 1, fewest transitions
  always_comb begin
    ones_in = 4'd0;
    for (int i = 0; i < 8; i++) begin
      ones_in = ones_in + {3'b000, data[i]};
    end
    use_xnor = (ones_in > 4'd4) || ((ones_in == 4'd4) && !data[0]);
    q_m_next[0] = data[0];
    for (int i = 1; i < 8; i++) begin
      q_m_next[i] = use_xnor ? !(q_m_next[i-1] ^ data[i]) : (q_m_next[i-1] ^ data[i]);
    end
    q_m_next[8] = !use_xnor;
  end

  always_ff @(posedge clk_25mhz) begin
    q_m <= q_m_next;
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      de_d   <= 1'b0;
      ctrl_d <= 2'b00;
    end else begin
      de_d   <= de;
      ctrl_d <= ctrl;
    end
  end

  // Stage 2, DC balance against the running disparity
  always_comb begin
    ones_q = 4'd0;
    for (int i = 0; i < 8; i++) begin
      ones_q = ones_q + {3'b000, q_m[i]};
    end
    // Ones minus zeros of the word
    q_diff = $signed({1'b0, ones_q, 1'b0}) - 6'sd8;
    sym_next.fields.use_xor = q_m[8];
    if ((disparity == 6'sd0) || (q_diff == 6'sd0)) begin
      sym_next.fields.invert = !q_m[8];
      sym_next.fields.data   = q_m[8] ? q_m[7:0] : ~q_m[7:0];
      disparity_next = q_m[8] ? disparity + q_diff : disparity - q_diff;
    end else if (((disparity > 6'sd0) && (q_diff > 6'sd0)) ||
                 ((disparity < 6'sd0) && (q_diff < 6'sd0))) begin
      sym_next.fields.invert = 1'b1;
      sym_next.fields.data   = ~q_m[7:0];
      disparity_next = disparity - q_diff + (q_m[8] ? 6'sd2 : 6'sd0);
    end else begin
      sym_next.fields.invert = 1'b0;
      sym_next.fields.data   = q_m[7:0];
      disparity_next = disparity + q_diff - (q_m[8] ? 6'sd0 : 6'sd2);
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      symbol    <= tmds_ctrl_00;
      disparity <= 6'sd0;
    end else if (!de_d) begin
      disparity <= 6'sd0;
      case (ctrl_d)
        2'b00:   symbol <= tmds_ctrl_00;
        2'b01:   symbol <= tmds_ctrl_01;
        2'b10:   symbol <= tmds_ctrl_10;
        default: symbol <= tmds_ctrl_11;
      endcase
    end else begin
      symbol    <= sym_next.raw;
      disparity <= disparity_next;
    end
  end

endmodule

`default_nettype wire

//--- design/ulx3s_top.sv
`timescale 1ns/100ps
`default_nettype none

module ulx3s_top (
  input  logic       clk_25mhz,
  input  logic [6:0] btn,
  input  logic       sd_miso,
  output logic [7:0] led,
  output logic       sd_clk,
  output logic       sd_csn,
  output logic       sd_mosi,
  output logic [9:0] tmds_red,
  output logic [9:0] tmds_green,
  output logic [9:0] tmds_blue
);

  logic reset;

  // btn[0] low holds the core in reset
  reset_stretch u_reset (
    .clk_25mhz (clk_25mhz),
    .ready     (btn[0]),
    .reset_out (reset)
  );

  main_core u_core (
    .clk_25mhz  (clk_25mhz),
    .reset      (reset),
    .btn        (btn[6:1]),
    .sd_miso    (sd_miso),
    .led        (led),
    .sd_clk     (sd_clk),
    .sd_csn     (sd_csn),
    .sd_mosi    (sd_mosi),
    .tmds_red   (tmds_red),
    .tmds_green (tmds_green),
    .tmds_blue  (tmds_blue)
  );

endmodule

`default_nettype wire

//--- design/video_timing.sv
`timescale 1ns/100ps
`default_nettype none

module video_timing
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  output logic [9:0] x,
  output logic [9:0] y,
  output logic       de,
  output logic       hsync,
  output logic       vsync
);

  logic [9:0] h_count;
  logic [9:0] v_count;
  logic       line_end;
  logic       frame_end;

  assign line_end  = (h_count == h_total - 10'd1);
  assign frame_end = (v_count == v_total - 10'd1);

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      h_count <= 10'd0;
      v_count <= 10'd0;
    end else if (line_end) begin
      h_count <= 10'd0;
      if (frame_end) begin
        v_count <= 10'd0;
      end else begin
        v_count <= v_count + 10'd1;
      end
    end else begin
      h_count <= h_count + 10'd1;
    end
  end

  assign x = h_count;
  assign y = v_count;

  // Visible area starts at the top left corner
  assign de = (h_count < h_active) && (v_count < v_active);

  // Sync follows the front porch, active high
  assign hsync = (h_count >= h_active + h_front) &&
                 (h_count < h_active + h_front + h_sync);
  assign vsync = (v_count >= v_active + v_front) &&
                 (v_count < v_active + v_front + v_sync);

endmodule

`default_nettype wire

//--- sim/tb_ulx3s_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ulx3s_top
  import board_pkg::*;
();

  logic       clk_25mhz;
  logic [6:0] btn;
  logic       sd_miso;
  logic [7:0] led;
  logic       sd_clk;
  logic       sd_csn;
  logic       sd_mosi;
  logic [9:0] tmds_red;
  logic [9:0] tmds_green;
  logic [9:0] tmds_blue;
  logic [7:0] card_byte;
  logic [2:0] card_bit;
  logic       sclk_seen;
  logic       csn_seen;
  logic [7:0] mosi_byte;
  int         mosi_bits;
  int         frames;
  int         errors;
  int         video_errors;
  int         pixels;
  int         vsync_ends;
  int         cycles;

  ulx3s_top u_dut (
    .clk_25mhz  (clk_25mhz),
    .btn        (btn),
    .sd_miso    (sd_miso),
    .led        (led),
    .sd_clk     (sd_clk),
    .sd_csn     (sd_csn),
    .sd_mosi    (sd_mosi),
    .tmds_red   (tmds_red),
    .tmds_green (tmds_green),
    .tmds_blue  (tmds_blue)
  );

  tb_video_check u_video (
    .clk_25mhz  (clk_25mhz),
    .tmds_red   (tmds_red),
    .tmds_green (tmds_green),
    .tmds_blue  (tmds_blue),
    .errors     (video_errors),
    .pixels     (pixels),
    .vsync_ends (vsync_ends)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = !clk_25mhz;
  end

  // 2.2 frames of video
  initial begin
    cycles = 0;
    while (cycles < (22 * int'(h_total) * int'(v_total)) / 10) begin
      @(posedge clk_25mhz);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycles);
    $display("Some tests failed");
    $finish;
  end

  // SD card model, and capture of the bits the core sends
  initial begin
    sd_miso   = 1'b1;
    sclk_seen = 1'b0;
    csn_seen  = 1'b1;
    card_bit  = 3'd7;
    mosi_byte = 8'h00;
    mosi_bits = 0;
    frames    = 0;
    forever begin
      @(negedge clk_25mhz);
      sclk_seen <= sd_clk;
      csn_seen  <= sd_csn;
      if (sd_csn) begin
        card_bit <= 3'd7;
        sd_miso  <= 1'b1;
      end else begin
        if (csn_seen) begin
          frames    <= frames + 1;
          mosi_bits <= 0;
          sd_miso   <= card_byte[7];
        end else if (sclk_seen && !sd_clk) begin
          card_bit <= card_bit - 3'd1;
          sd_miso  <= card_byte[card_bit - 3'd1];
        end
        if (!sclk_seen && sd_clk) begin
          mosi_byte <= {mosi_byte[6:0], sd_mosi};
          mosi_bits <= mosi_bits + 1;
        end
      end
    end
  end

  function automatic logic [7:0] spi_expect(input logic [3:0] nibble);
    return {nibble, 4'h5};
  endfunction

  task automatic check_reset_stretch();
    int i;
    int waited;
    for (i = 0; i < int'(reset_stretch_len); i++) begin
      @(negedge clk_25mhz);
      if (tmds_red != tmds_ctrl_00 || tmds_green != tmds_ctrl_00 ||
          tmds_blue != tmds_ctrl_00 || !sd_csn || led != 8'h00) begin
        $display("FAIL %0t: outputs left reset %0d cycles after btn[0] rose", $time, i + 1);
        errors++;
      end
    end
    // Colour register plus encoder pipeline
    waited = 0;
    while (tmds_blue == tmds_ctrl_00 && waited < tmds_latency + 1) begin
      @(negedge clk_25mhz);
      waited++;
    end
    if (tmds_blue == tmds_ctrl_00) begin
      $display("FAIL %0t: video did not start after reset", $time);
      errors++;
    end
  endtask

  task automatic run_transfer(input logic [3:0] nibble, input logic second_press);
    logic [31:0] rnd;
    int          first_frame;
    int          waited;
    rnd         = $urandom();
    card_byte   = rnd[7:0];
    first_frame = frames;
    @(negedge clk_25mhz);
    btn[6:3] = nibble;
    btn[1]   = 1'b1;
    // Second edge lands while the byte is still in flight
    if (second_press) begin
      repeat (4) @(negedge clk_25mhz);
      btn[1] = 1'b0;
      repeat (3) @(negedge clk_25mhz);
      btn[1] = 1'b1;
    end
    waited = 0;
    while (!(frames == first_frame + 1 && sd_csn) && waited < 200) begin
      @(negedge clk_25mhz);
      waited++;
    end
    if (waited >= 200) begin
      $display("No complete SPI frame followed the btn[1] press at %0t", $time);
      errors++;
    end
    repeat (2) @(negedge clk_25mhz);
    if (mosi_bits != 8 || mosi_byte != spi_expect(nibble)) begin
      $display("FAIL %0t: MOSI %h in %0d clocks, expected %h", $time, mosi_byte, mosi_bits,
               spi_expect(nibble));
      errors++;
    end
    if (led != card_byte) begin
      $display("FAIL %0t: led %h, card sent %h", $time, led, card_byte);
      errors++;
    end
    btn[1] = 1'b0;
    repeat (60) @(negedge clk_25mhz);
    if (frames != first_frame + 1) begin
      $display("FAIL %0t: %0d SPI frames for one transfer", $time, frames - first_frame);
      errors++;
    end
  endtask

  initial begin
    logic [31:0] rnd;
    btn    = 7'd0;
    errors = 0;
    rnd    = $urandom(32'h3c95_3467);
    repeat (4) @(negedge clk_25mhz);
    btn[0] = 1'b1;
    check_reset_stretch();
    for (int t = 0; t < 6; t++) begin
      rnd = $urandom();
      run_transfer(rnd[3:0], (t == 2) || (t == 4));
    end
    // Two whole frames through the video checker
    while (vsync_ends < 2) begin
      @(posedge clk_25mhz);
    end
    if (pixels < int'(h_active) * int'(v_active)) begin
      $display("The video checker saw only %0d pixels", pixels);
      errors++;
    end
    $display("Error count: %0d (SPI and reset %0d, video %0d)", errors + video_errors,
             errors, video_errors);
    if (errors + video_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_video_check.sv
`timescale 1ns/100ps
`default_nettype none

module tb_video_check
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic [9:0] tmds_red,
  input  logic [9:0] tmds_green,
  input  logic [9:0] tmds_blue,
  output int         errors,
  output int         pixels,
  output int         vsync_ends
);

  logic [8:0] dec_r;
  logic [8:0] dec_g;
  logic [8:0] dec_b;
  logic       active;
  logic       was_active;
  logic       hs;
  logic       hs_prev;
  logic       vs;
  logic       vs_prev;
  logic [9:0] px;
  logic [9:0] ln;
  logic [5:0] xc;
  logic [5:0] yc;
  int         cycle;
  int         hs_rise;
  int         vs_rise;
  int         dc_r;
  int         dc_g;
  int         dc_b;

  // Bit 8 set for a control word, with {c1, c0} in bits 1:0
  function automatic logic [8:0] tmds_decode(input logic [9:0] code);
    tmds_symbol_t sym;
    logic [7:0]   d;
    logic [8:0]   result;
    sym.raw = code;
    result  = 9'd0;
    case (code)
      tmds_ctrl_00: result = 9'h100;
      tmds_ctrl_01: result = 9'h101;
      tmds_ctrl_10: result = 9'h102;
      tmds_ctrl_11: result = 9'h103;
      default: begin
        // Undo the inversion, then the XOR or XNOR chain
        d = sym.fields.invert ? ~sym.fields.data : sym.fields.data;
        result[0] = d[0];
        for (int i = 1; i < 8; i++) begin
          result[i] = sym.fields.use_xor ? (d[i] ^ d[i-1]) : !(d[i] ^ d[i-1]);
        end
      end
    endcase
    return result;
  endfunction

  function automatic logic [7:0] widen(input logic [5:0] c);
    return {c, c[5:4]};
  endfunction

  // Ones minus zeros of one symbol
  function automatic int balance(input logic [9:0] code);
    return 2 * $countones(code) - 10;
  endfunction

  initial begin
    errors     = 0;
    pixels     = 0;
    vsync_ends = 0;
    was_active = 1'b0;
    hs_prev    = 1'b0;
    vs_prev    = 1'b0;
    px         = 10'd0;
    ln         = 10'd0;
    cycle      = 0;
    hs_rise    = -1;
    vs_rise    = -1;
    dc_r       = 0;
    dc_g       = 0;
    dc_b       = 0;
    forever begin
      @(negedge clk_25mhz);
      dec_r  = tmds_decode(tmds_red);
      dec_g  = tmds_decode(tmds_green);
      dec_b  = tmds_decode(tmds_blue);
      active = !dec_b[8];
      hs     = dec_b[8] && dec_b[0];
      vs     = dec_b[8] && dec_b[1];

      if (hs && !hs_prev) begin
        if (hs_rise >= 0 && cycle - hs_rise != int'(h_total)) begin
          $display("FAIL %0t: hsync period %0d cycles", $time, cycle - hs_rise);
          errors++;
        end
        hs_rise = cycle;
      end
      if (!hs && hs_prev && hs_rise >= 0 && cycle - hs_rise != int'(h_sync)) begin
        $display("FAIL %0t: hsync width %0d cycles", $time, cycle - hs_rise);
        errors++;
      end

      // Vertical sync measured in pixel clocks, lines counted from data runs
      if (vs && !vs_prev) begin
        if (vs_rise >= 0 && cycle - vs_rise != int'(v_total) * int'(h_total)) begin
          $display("FAIL %0t: vsync period %0d cycles", $time, cycle - vs_rise);
          errors++;
        end
        if (ln != v_active) begin
          $display("FAIL %0t: %0d active lines before vsync", $time, ln);
          errors++;
        end
        vs_rise = cycle;
      end
      if (!vs && vs_prev && vs_rise >= 0) begin
        if (cycle - vs_rise != int'(v_sync) * int'(h_total)) begin
          $display("FAIL %0t: vsync width %0d cycles", $time, cycle - vs_rise);
          errors++;
        end
        vsync_ends++;
        ln = 10'd0;
      end

      if (active) begin
        xc = px[7:2];
        yc = ln[7:2];
        if (dec_r[8] || dec_g[8]) begin
          $display("FAIL %0t: lanes out of step at pixel (%0d,%0d)", $time, px, ln);
          errors++;
        end else if (dec_r[7:0] != widen(xc) || dec_g[7:0] != widen(yc) ||
                     dec_b[7:0] != widen(xc ^ yc)) begin
          $display("FAIL %0t: pixel (%0d,%0d) decoded as %h %h %h", $time, px, ln,
                   dec_r[7:0], dec_g[7:0], dec_b[7:0]);
          errors++;
        end
        dc_r = dc_r + balance(tmds_red);
        dc_g = dc_g + balance(tmds_green);
        dc_b = dc_b + balance(tmds_blue);
        px = px + 10'd1;
        pixels++;
      end else begin
        if (tmds_red != tmds_ctrl_00 || tmds_green != tmds_ctrl_00) begin
          $display("FAIL %0t: red or green not idle in blanking", $time);
          errors++;
        end
        if (was_active) begin
          if (px != h_active) begin
            $display("FAIL %0t: line %0d held %0d pixels", $time, ln, px);
            errors++;
          end
          if (dc_r > 10 || dc_r < -10 || dc_g > 10 || dc_g < -10 ||
              dc_b > 10 || dc_b < -10) begin
            $display("FAIL %0t: line %0d balance %0d %0d %0d", $time, ln, dc_r, dc_g, dc_b);
            errors++;
          end
          px   = 10'd0;
          ln   = ln + 10'd1;
          dc_r = 0;
          dc_g = 0;
          dc_b = 0;
        end
      end
      was_active = active;
      hs_prev    = hs;
      vs_prev    = vs;
      cycle++;
    end
  end

endmodule

`default_nettype wire
